/* pmp_access_gate.sv */
// data request gate and error reporting

`timescale 1ns/1ps

module pmp_access_gate import pmp_pkg::*; (
   input  logic                     clk,
   input  logic                     rst_n,

   input  priv_lvl_e                priv_mode_i,
   input  logic [N_PMP_ENTRIES-1:0] region_match_i,

   // core and memory handshake
   input  logic                     data_req_i,
   input  logic                     data_gnt_i,
   input  logic                     data_err_ack_i,
   output logic                     data_req_o,
   output logic                     data_gnt_o,
   output logic                     data_err_o
);

   // access permitted this cycle
   logic       allowed;
   // request that has to be turned into an error
   logic       blocked;

   err_state_e err_state_q;
   err_state_e err_state_d;

   ////////////////////////////////////////
   // request and grant gating
   ////////////////////////////////////////

   // machine mode skips every rule
   assign allowed = (priv_mode_i == PRIV_M) || (|region_match_i);

   // a blocked request never reaches memory
   assign data_req_o = data_req_i & allowed;
   assign data_gnt_o = data_gnt_i & allowed;

   assign blocked = data_req_i & ~allowed;

   ////////////////////////////////////////
   // error fsm
   ////////////////////////////////////////

   always_comb
   begin
      err_state_d = err_state_q;
      unique case (err_state_q)
         ERR_IDLE:
         begin
            // report on the next cycle
            if (blocked)
            begin
               err_state_d = ERR_GIVE;
            end
         end
         ERR_GIVE:
         begin
            // hold until the core acknowledges
            // further blocked requests do not stack up
            if (data_err_ack_i)
            begin
               err_state_d = ERR_IDLE;
            end
         end
         default:
         begin
            err_state_d = ERR_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         err_state_q <= ERR_IDLE;
      end
      else
      begin
         err_state_q <= err_state_d;
      end
   end

   // error is a plain decode of the state register
   assign data_err_o = (err_state_q == ERR_GIVE);

endmodule

/* pmp_cfg_decoder.sv */
// protection configuration decoder

`timescale 1ns/1ps

module pmp_cfg_decoder import pmp_pkg::*; (
   input  logic [N_PMP_ENTRIES-1:0][ADDR_W-1:0] pmp_addr_i,
   input  logic [N_PMP_ENTRIES-1:0][CFG_W-1:0]  pmp_cfg_i,
   pmp_rule_if.decoder                          rule_o [N_PMP_ENTRIES]
);

   // napot mask: clear the trailing ones and the zero just above them
   // an address of all ones leaves nothing, the whole space matches
   function automatic logic [WADDR_W-1:0] napot_mask(input logic [WADDR_W-1:0] addr);
      logic [WADDR_W-1:0] mask;
      logic               in_run;
      mask   = '1;
      in_run = 1'b1;
      for (int b = 0; b < WADDR_W; b++)
      begin
         if (in_run)
         begin
            mask[b] = 1'b0;
            // stop after the first zero has been cleared
            in_run  = addr[b];
         end
      end
      return mask;
   endfunction

   // word address of each entry
   logic [N_PMP_ENTRIES-1:0][WADDR_W-1:0] entry_addr;
   // lower tor bound, taken from the entry below
   logic [N_PMP_ENTRIES-1:0][WADDR_W-1:0] tor_base;

   ////////////////////////////////////////
   // per entry expansion
   ////////////////////////////////////////

   for (genvar g = 0; g < N_PMP_ENTRIES; g++)
   begin : g_entry
      assign entry_addr[g] = pmp_addr_i[g][WADDR_W-1:0];

      // entry 0 starts its tor range at address zero
      if (g == 0)
      begin : g_first
         assign tor_base[g] = '0;
      end
      else
      begin : g_next
         assign tor_base[g] = pmp_addr_i[g-1][WADDR_W-1:0];
      end

      always_comb
      begin
         rule_o[g].mode   = pmp_mode_e'(pmp_cfg_i[g][CFG_MODE_LSB +: CFG_MODE_W]);
         rule_o[g].perm_r = pmp_cfg_i[g][CFG_R_BIT];
         rule_o[g].perm_w = pmp_cfg_i[g][CFG_W_BIT];
         // defaults cover an entry that is off
         rule_o[g].base   = '0;
         rule_o[g].top    = '0;
         rule_o[g].mask   = '1;
         unique case (rule_o[g].mode)
            PMP_TOR:
            begin
               rule_o[g].base = tor_base[g];
               rule_o[g].top  = entry_addr[g];
            end
            PMP_NA4:
            begin
               // single word, exact compare
               rule_o[g].base = entry_addr[g];
               rule_o[g].top  = entry_addr[g];
            end
            PMP_NAPOT:
            begin
               rule_o[g].mask = napot_mask(entry_addr[g]);
               rule_o[g].base = entry_addr[g] & napot_mask(entry_addr[g]);
               rule_o[g].top  = entry_addr[g];
            end
            default:
            begin
               rule_o[g].mask = '1;
            end
         endcase
      end
   end

endmodule

/* pmp_checker.sv */
// physical memory protection checker, data side

`timescale 1ns/1ps

module pmp_checker import pmp_pkg::*; (
   input  logic                                 clk,
   input  logic                                 rst_n,

   // current privilege of the core
   input  priv_lvl_e                            priv_mode_i,

   // protection registers
   input  logic [N_PMP_ENTRIES-1:0][ADDR_W-1:0] pmp_addr_i,
   input  logic [N_PMP_ENTRIES-1:0][CFG_W-1:0]  pmp_cfg_i,

   // load/store unit side
   input  logic                                 data_req_i,
   input  logic [ADDR_W-1:0]                    data_addr_i,
   input  logic                                 data_we_i,
   output logic                                 data_gnt_o,

   // memory side
   output logic                                 data_req_o,
   input  logic                                 data_gnt_i,
   output logic [ADDR_W-1:0]                    data_addr_o,
   output logic                                 data_err_o,
   input  logic                                 data_err_ack_i
);

   // one decoded rule per entry
   pmp_rule_if rule_if [N_PMP_ENTRIES] ();

   // request address without the byte offset
   logic [WADDR_W-1:0]       word_addr;
   // one bit per entry that allows this access
   logic [N_PMP_ENTRIES-1:0] region_match;

   assign word_addr = data_addr_i[ADDR_W-1:BYTE_OFF_W];

   // address goes to memory unchanged
   assign data_addr_o = data_addr_i;

   ////////////////////////////////////////
   // rule decode
   ////////////////////////////////////////

   pmp_cfg_decoder i_cfg_decoder (
      .pmp_addr_i (pmp_addr_i),
      .pmp_cfg_i  (pmp_cfg_i),
      .rule_o     (rule_if)
   );

   ////////////////////////////////////////
   // matcher array
   ////////////////////////////////////////

   for (genvar g = 0; g < N_PMP_ENTRIES; g++)
   begin : g_matcher
      pmp_rule_matcher i_rule_matcher (
         .rule_i      (rule_if[g]),
         .word_addr_i (word_addr),
         .we_i        (data_we_i),
         .match_o     (region_match[g])
      );
   end

   ////////////////////////////////////////
   // gate and error
   ////////////////////////////////////////

   pmp_access_gate i_access_gate (
      .clk            (clk),
      .rst_n          (rst_n),
      .priv_mode_i    (priv_mode_i),
      .region_match_i (region_match),
      .data_req_i     (data_req_i),
      .data_gnt_i     (data_gnt_i),
      .data_err_ack_i (data_err_ack_i),
      .data_req_o     (data_req_o),
      .data_gnt_o     (data_gnt_o),
      .data_err_o     (data_err_o)
   );

endmodule

/* pmp_checker_properties.sv */
// pmp checker handshake properties

`timescale 1ns/1ps

module pmp_checker_properties import pmp_pkg::*; (
   input logic              clk,
   input logic              rst_n,
   input priv_lvl_e         priv_mode_i,
   input logic              data_req_i,
   input logic [ADDR_W-1:0] data_addr_i,
   input logic              data_gnt_i,
   input logic              data_req_o,
   input logic              data_gnt_o,
   input logic [ADDR_W-1:0] data_addr_o,
   input logic              data_err_o,
   input logic              data_err_ack_i
);

   // number of failed properties so far
   int unsigned fail_count = 0;

   function automatic void note_fail(input string what);
      fail_count++;
      $error("%s", what);
   endfunction

   // address reaches memory untouched
   a_addr_pass: assert property (@(posedge clk) disable iff (!rst_n)
      data_addr_o == data_addr_i)
      else note_fail("data_addr_o differs from data_addr_i");

   // nothing is forwarded without a request from the core
   a_req_source: assert property (@(posedge clk) disable iff (!rst_n)
      data_req_o |-> data_req_i)
      else note_fail("data_req_o high without data_req_i");

   // machine mode is a plain wire
   a_m_bypass: assert property (@(posedge clk) disable iff (!rst_n)
      (priv_mode_i == PRIV_M) |-> (data_req_o == data_req_i) && (data_gnt_o == data_gnt_i))
      else note_fail("machine mode request or grant not passed through");

   // error only follows a blocked request
   a_err_cause: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(data_err_o) |-> $past(data_req_i && !data_req_o))
      else note_fail("data_err_o rose without a blocked request");

   // held until acknowledged, dropped one cycle later
   a_err_hold: assert property (@(posedge clk) disable iff (!rst_n)
      data_err_o && !data_err_ack_i |=> data_err_o)
      else note_fail("data_err_o dropped without acknowledgement");

   a_err_drop: assert property (@(posedge clk) disable iff (!rst_n)
      data_err_o && data_err_ack_i |=> !data_err_o)
      else note_fail("data_err_o still high after acknowledgement");

   // reset clears the error
   a_err_reset: assert property (@(posedge clk)
      !rst_n |=> !data_err_o)
      else note_fail("data_err_o high after reset");

endmodule

bind pmp_checker pmp_checker_properties i_props (
   .clk            (clk),
   .rst_n          (rst_n),
   .priv_mode_i    (priv_mode_i),
   .data_req_i     (data_req_i),
   .data_addr_i    (data_addr_i),
   .data_gnt_i     (data_gnt_i),
   .data_req_o     (data_req_o),
   .data_gnt_o     (data_gnt_o),
   .data_addr_o    (data_addr_o),
   .data_err_o     (data_err_o),
   .data_err_ack_i (data_err_ack_i)
);

/* pmp_pkg.sv */
// pmp checker shared definitions

package pmp_pkg;

   ////////////////////////////////////////
   // widths
   ////////////////////////////////////////

   // byte address as seen by the load/store unit
   localparam int unsigned ADDR_W = 32;

   // word address, also the usable part of an address register
   localparam int unsigned WADDR_W = 30;

   // low address bits that select a byte inside a word
   localparam int unsigned BYTE_OFF_W = ADDR_W - WADDR_W;

   // number of protection entries checked in parallel
   localparam int unsigned N_PMP_ENTRIES = 4;

   ////////////////////////////////////////
   // configuration byte layout
   ////////////////////////////////////////

   localparam int unsigned CFG_W = 8;

   // permission bits
   localparam int unsigned CFG_R_BIT = 0;
   localparam int unsigned CFG_W_BIT = 1;
   // execute bit, only meaningful on the fetch side
   localparam int unsigned CFG_X_BIT = 2;

   // address matching mode, two bits wide
   localparam int unsigned CFG_MODE_LSB = 3;
   localparam int unsigned CFG_MODE_W = 2;

   ////////////////////////////////////////
   // enums
   ////////////////////////////////////////

   // address matching mode of one entry
   typedef enum logic [CFG_MODE_W-1:0]
   {
      PMP_OFF   = 2'b00,
      PMP_TOR   = 2'b01,
      PMP_NA4   = 2'b10,
      PMP_NAPOT = 2'b11
   } pmp_mode_e;

   // privilege level of the current access
   // level 2 is reserved and never used
   typedef enum logic [1:0]
   {
      PRIV_U = 2'b00,
      PRIV_S = 2'b01,
      PRIV_M = 2'b11
   } priv_lvl_e;

   // error reporting state
   typedef enum logic
   {
      ERR_IDLE = 1'b0,
      ERR_GIVE = 1'b1
   } err_state_e;

endpackage

/* pmp_rule_if.sv */
// decoded protection rule

`timescale 1ns/1ps

interface pmp_rule_if import pmp_pkg::*; ();

   // matching mode, off means the rule never hits
   pmp_mode_e            mode;
   // read and write permission of the region
   logic                 perm_r;
   logic                 perm_w;
   // lower bound for tor, region address for na4 and napot
   logic [WADDR_W-1:0]   base;
   // upper bound for tor, exclusive
   logic [WADDR_W-1:0]   top;
   // napot compare mask, all ones for na4
   logic [WADDR_W-1:0]   mask;

   // decoder side drives the rule
   modport decoder (
      output mode, perm_r, perm_w, base, top, mask
   );

   // matcher side only looks at it
   modport matcher (
      input  mode, perm_r, perm_w, base, top, mask
   );

endinterface

/* pmp_rule_matcher.sv */
// single protection rule matcher

`timescale 1ns/1ps

module pmp_rule_matcher import pmp_pkg::*; (
   pmp_rule_if.matcher        rule_i,
   input  logic [WADDR_W-1:0] word_addr_i,
   input  logic               we_i,
   output logic               match_o
);

   // access type allowed by this rule
   logic perm_ok;
   // address falls inside the rule's region
   logic addr_hit;

   ////////////////////////////////////////
   // permission check
   ////////////////////////////////////////

   // loads need read, stores need write
   always_comb
   begin
      if (we_i)
      begin
         perm_ok = rule_i.perm_w;
      end
      else
      begin
         perm_ok = rule_i.perm_r;
      end
   end

   ////////////////////////////////////////
   // address compare
   ////////////////////////////////////////

   always_comb
   begin
      unique case (rule_i.mode)
         PMP_TOR:
         begin
            // unsigned, top itself is outside
            addr_hit = (word_addr_i >= rule_i.base) && (word_addr_i < rule_i.top);
         end
         PMP_NA4:
         begin
            addr_hit = (word_addr_i == rule_i.base);
         end
         PMP_NAPOT:
         begin
            // mask drops the bits that vary inside the region
            addr_hit = ((word_addr_i & rule_i.mask) == rule_i.base);
         end
         default:
         begin
            addr_hit = 1'b0;
         end
      endcase
   end

   // hit only when both region and access type agree
   assign match_o = perm_ok & addr_hit;

endmodule

/* src.f */
pmp_pkg.sv
pmp_rule_if.sv
pmp_cfg_decoder.sv
pmp_rule_matcher.sv
pmp_access_gate.sv
pmp_checker.sv
pmp_checker_properties.sv
tb_pmp_checker.sv

/* tb_pmp_checker.sv */
// pmp checker testbench

`timescale 1ns/1ps

module tb_pmp_checker import pmp_pkg::*; ();

   // cycles any single wait may take
   localparam int unsigned WAIT_LIMIT = 20;

   logic                                 clk;
   logic                                 rst_n;
   priv_lvl_e                            priv_mode;
   logic [N_PMP_ENTRIES-1:0][ADDR_W-1:0] pmp_addr;
   logic [N_PMP_ENTRIES-1:0][CFG_W-1:0]  pmp_cfg;
   logic                                 core_req;
   logic [ADDR_W-1:0]                    core_addr;
   logic                                 core_we;
   logic                                 core_gnt;
   logic                                 mem_req;
   logic                                 mem_gnt;
   logic [ADDR_W-1:0]                    mem_addr;
   logic                                 err;
   logic                                 err_ack;

   // expected error flag and gating
   logic        err_exp;
   logic        exp_allow;
   int unsigned errors;
   int unsigned total;
   integer      seed;
   integer      i;
   logic [31:0] rnd;

   pmp_checker i_dut (
      .clk            (clk),
      .rst_n          (rst_n),
      .priv_mode_i    (priv_mode),
      .pmp_addr_i     (pmp_addr),
      .pmp_cfg_i      (pmp_cfg),
      .data_req_i     (core_req),
      .data_addr_i    (core_addr),
      .data_we_i      (core_we),
      .data_gnt_o     (core_gnt),
      .data_req_o     (mem_req),
      .data_gnt_i     (mem_gnt),
      .data_addr_o    (mem_addr),
      .data_err_o     (err),
      .data_err_ack_i (err_ack)
   );

   always
   begin
      #2 clk = ~clk;
   end

   ////////////////////////////////////////
   // reference permission model
   ////////////////////////////////////////

   function automatic logic [CFG_W-1:0] cfg_byte(input pmp_mode_e mode, input logic r,
                                                 input logic w);
      logic [CFG_W-1:0] c;
      c = '0;
      c[CFG_R_BIT] = r;
      c[CFG_W_BIT] = w;
      c[CFG_MODE_LSB +: CFG_MODE_W] = mode;
      return c;
   endfunction

   // entry covers the word and allows this access type
   function automatic logic entry_allows(input int e, input logic [ADDR_W-1:0] addr,
                                         input logic we);
      logic [WADDR_W-1:0] wa;
      logic [WADDR_W-1:0] ea;
      logic [WADDR_W-1:0] lo;
      logic               perm;
      logic               hit;
      int                 t;
      wa = addr[ADDR_W-1:2];
      ea = pmp_addr[e][WADDR_W-1:0];
      perm = we ? pmp_cfg[e][CFG_W_BIT] : pmp_cfg[e][CFG_R_BIT];
      lo = '0;
      if (e > 0)
      begin
         lo = pmp_addr[e-1][WADDR_W-1:0];
      end
      // trailing ones give the napot size
      t = 0;
      while (t < WADDR_W && ea[t])
      begin
         t++;
      end
      case (pmp_mode_e'(pmp_cfg[e][CFG_MODE_LSB +: CFG_MODE_W]))
         PMP_TOR:   hit = (wa >= lo) && (wa < ea);
         PMP_NA4:   hit = (wa == ea);
         // 2^(t+1) words, the whole space once the run reaches the top bit
         PMP_NAPOT: hit = (t >= WADDR_W - 1) || ((wa >> (t + 1)) == (ea >> (t + 1)));
         default:   hit = 1'b0;
      endcase
      return perm && hit;
   endfunction

   function automatic logic access_allowed(input logic [ADDR_W-1:0] addr, input logic we);
      logic ok;
      ok = (priv_mode == PRIV_M);
      for (int e = 0; e < N_PMP_ENTRIES; e++)
      begin
         ok = ok | entry_allows(e, addr, we);
      end
      return ok;
   endfunction

   // error register as the handshake rules describe it
   always @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         err_exp <= 1'b0;
      else if (err_exp)
         err_exp <= !err_ack;
      else
         err_exp <= core_req && !access_allowed(core_addr, core_we);
   end

   ////////////////////////////////////////
   // checks at mid cycle
   ////////////////////////////////////////

   always @(negedge clk)
   begin
      if (rst_n)
      begin
         exp_allow = access_allowed(core_addr, core_we);
         assert (mem_req === (core_req && exp_allow))
         else
         begin
            errors++;
            $display("Fail at %0t: data_req_o expected %0b got %0b", $time,
                     core_req && exp_allow, mem_req);
         end
         assert (core_gnt === (mem_gnt && exp_allow))
         else
         begin
            errors++;
            $display("Fail at %0t: data_gnt_o expected %0b got %0b", $time,
                     mem_gnt && exp_allow, core_gnt);
         end
         assert (err === err_exp)
         else
         begin
            errors++;
            $display("Fail at %0t: data_err_o expected %0b got %0b", $time, err_exp, err);
         end
      end
   end

   ////////////////////////////////////////
   // stimulus tasks
   ////////////////////////////////////////

   task automatic wait_err(input logic level);
      int unsigned n;
      n = 0;
      do
      begin
         @(negedge clk);
         n++;
      end
      while (err !== level && n < WAIT_LIMIT);
      if (err !== level)
      begin
         errors++;
         $display("timeout: data_err_o never became %0b", level);
      end
   endtask

   task automatic wait_gnt();
      int unsigned n;
      n = 0;
      do
      begin
         @(negedge clk);
         n++;
      end
      while (core_gnt !== 1'b1 && n < WAIT_LIMIT);
      if (core_gnt !== 1'b1)
      begin
         errors++;
         $display("timeout: grant never reached the core");
      end
   endtask

   // one core access, delay stalls the grant or the acknowledgement
   task automatic do_access(input logic [ADDR_W-1:0] addr, input logic we,
                            input int unsigned delay);
      @(posedge clk);
      #1;
      core_req  = 1'b1;
      core_addr = addr;
      core_we   = we;
      if (access_allowed(addr, we))
      begin
         // grant held back for delay cycles, zero means with the request
         repeat (delay)
         begin
            @(posedge clk);
            #1;
         end
         mem_gnt = 1'b1;
         wait_gnt();
      end
      else
      begin
         wait_err(1'b1);
         // request stays up while the error is held
         repeat (delay) @(posedge clk);
         @(posedge clk);
         #1;
         core_req = 1'b0;
         err_ack  = 1'b1;
         @(posedge clk);
         #1;
         err_ack = 1'b0;
         wait_err(1'b0);
      end
      @(posedge clk);
      #1;
      core_req = 1'b0;
      mem_gnt  = 1'b0;
   endtask

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////

   initial
   begin
      seed      = 5920;
      errors    = 0;
      clk       = 1'b0;
      rst_n     = 1'b0;
      priv_mode = PRIV_M;
      pmp_addr  = '0;
      pmp_cfg   = '0;
      core_req  = 1'b0;
      core_addr = '0;
      core_we   = 1'b0;
      mem_gnt   = 1'b0;
      err_ack   = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // machine mode, all entries off, random traffic
      for (i = 0; i < 40; i++)
      begin
         @(posedge clk);
         #1;
         core_req  = $random(seed);
         core_addr = $random(seed);
         core_we   = $random(seed);
         mem_gnt   = $random(seed);
      end
      @(posedge clk);
      #1;
      core_req  = 1'b0;
      mem_gnt   = 1'b0;
      priv_mode = PRIV_U;
      // na4 read only word at 0x1000
      pmp_addr[0] = 32'h0000_0400;
      pmp_cfg[0]  = cfg_byte(PMP_NA4, 1'b1, 1'b0);
      do_access(32'h0000_1000, 1'b0, 1);
      do_access(32'h0000_1000, 1'b1, 0);
      do_access(32'h0000_1004, 1'b0, 0);

      // tor from 0x2000 up to 0x2040
      pmp_cfg     = '0;
      pmp_addr[0] = 32'h0000_0800;
      pmp_addr[1] = 32'h0000_0810;
      pmp_cfg[1]  = cfg_byte(PMP_TOR, 1'b1, 1'b1);
      do_access(32'h0000_2000, 1'b0, 0);
      do_access(32'h0000_2040, 1'b0, 0);
      do_access(32'h0000_1ffc, 1'b1, 0);
      do_access(32'h0000_203c, 1'b1, 2);

      // napot 32 bytes at 0x4000 read only, 4 KB at 0x10000 read write
      pmp_cfg     = '0;
      pmp_addr[2] = 32'h0000_1003;
      pmp_cfg[2]  = cfg_byte(PMP_NAPOT, 1'b1, 1'b0);
      pmp_addr[3] = 32'h0000_41ff;
      pmp_cfg[3]  = cfg_byte(PMP_NAPOT, 1'b1, 1'b1);
      for (i = 0; i < 12; i++)
      begin
         rnd = $random(seed);
         do_access(32'h0000_4000 + (rnd & 32'h1f), rnd[31], 0);
         do_access(32'h0001_0000 + (rnd & 32'hfff), rnd[30], 1);
      end
      do_access(32'h0000_3ffc, 1'b0, 0);
      do_access(32'h0000_4020, 1'b0, 0);
      do_access(32'h0000_fffc, 1'b1, 0);
      do_access(32'h0001_1000, 1'b1, 0);

      // late acknowledgement, then a stalled grant
      do_access(32'h0000_8000, 1'b0, 4);
      do_access(32'h0001_0010, 1'b1, 5);

      repeat (2) @(posedge clk);
      total = errors + i_dut.i_props.fail_count;
      $display("testbench errors %0d, assertion failures %0d", errors,
               i_dut.i_props.fail_count);
      if (total == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule
